// File: mipsPkg.sv
package mipsPkg;

    // Plain vector widths
    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;
    typedef logic [4:0]  shamtT;

    // Kept primary opcodes, SPECIAL selects on funct
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,
        OP_J       = 6'd2,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LW      = 6'd35,
        OP_SW      = 6'd43
    } opcodeT;

    // Kept SPECIAL funct codes
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } functT;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALT
    } cpuStateT;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } aluOpT;

    // R-type view of the low half
    typedef struct packed {
        regIdxT rd;
        shamtT  shamt;
        functT  funct;
    } rFieldsT;

    // Low half is either rd/shamt/funct or the 16-bit immediate
    typedef union packed {
        rFieldsT     r;
        logic [15:0] immediate;
    } lowHalfT;

    typedef struct packed {
        opcodeT  opcode;
        regIdxT  rs;
        regIdxT  rt;
        lowHalfT low;
    } instrT;

    typedef struct packed {
        logic   enable;
        regIdxT idx;
        wordT   data;
    } regWriteT;

    typedef struct packed {
        logic read;
        logic write;
        wordT address;
        wordT storeData;
    } busCmdT;

endpackage

// File: mipsAlu.sv
module mipsAlu import mipsPkg::*; (
    input  aluOpT aluOp,
    input  wordT  aluA,
    input  wordT  aluB,
    input  shamtT aluShamt,
    output wordT  aluResult
);

    logic signedLess;
    logic unsignedLess;

    assign signedLess   = $signed(aluA) < $signed(aluB);
    assign unsignedLess = aluA < aluB;

    always_comb begin
        case (aluOp)
            // Wrapping add and subtract, no overflow trap
            ALU_ADD: aluResult = aluA + aluB;
            ALU_SUB: aluResult = aluA - aluB;

            ALU_AND: aluResult = aluA & aluB;
            ALU_OR:  aluResult = aluA | aluB;
            ALU_XOR: aluResult = aluA ^ aluB;

            // Set on less than
            ALU_SLT:  aluResult = {31'd0, signedLess};
            ALU_SLTU: aluResult = {31'd0, unsignedLess};

            // Shifts act on rt by the shamt field
            ALU_SLL: aluResult = aluB << aluShamt;
            ALU_SRL: aluResult = aluB >> aluShamt;
            ALU_SRA: aluResult = wordT'($signed(aluB) >>> aluShamt);

            // Immediate into the upper half
            ALU_LUI: aluResult = {aluB[15:0], 16'h0000};

            default: aluResult = '0;
        endcase
    end

endmodule

// File: mipsRegFile.sv
module mipsRegFile import mipsPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  regIdxT   rsIdx,
    input  regIdxT   rtIdx,
    output wordT     rsData,
    output wordT     rtData,
    input  regWriteT regWrite,
    output wordT     v0Data
);

    wordT regs [32];

    // Register 0 is never written so it reads as zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite.enable && regWrite.idx != 5'd0) begin
            regs[regWrite.idx] <= regWrite.data;
        end
    end

    // Combinational read ports
    assign rsData = regs[rsIdx];
    assign rtData = regs[rtIdx];

    // Result register v0
    assign v0Data = regs[2];

endmodule

// File: mipsBusPort.sv
module mipsBusPort import mipsPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  busCmdT     busCmd,
    output logic       busDone,
    output wordT       busWord,

    output wordT       address,
    output logic       read,
    output logic       write,
    input  logic       waitrequest,
    output wordT       writedata,
    output logic [3:0] byteenable,
    input  wordT       readdata
);

    logic busy;

    // Bus byte order is the reverse of the word byte order
    function automatic wordT swapBytes(input wordT w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign busy    = read || write;
    assign busDone = busy && !waitrequest;

    // Word accesses only
    assign byteenable = 4'b1111;

    // Strobes drop after the completing cycle, so a command is issued once
    always_ff @(posedge clk) begin
        if (reset) begin
            read  <= 1'b0;
            write <= 1'b0;
        end else if (busDone) begin
            read  <= 1'b0;
            write <= 1'b0;
        end else if (!busy) begin
            read  <= busCmd.read;
            write <= busCmd.write;
        end
    end

    always_ff @(posedge clk) begin
        // Address and data held while waitrequest stalls
        if (!busy) begin
            address   <= busCmd.address;
            writedata <= swapBytes(busCmd.storeData);
        end
        if (read && !waitrequest) begin
            busWord <= swapBytes(readdata);
        end
    end

endmodule

// File: mipsSequencer.sv
module mipsSequencer import mipsPkg::*; #(
    parameter wordT resetVector = 32'hBFC0_0000
) (
    input  logic     clk,
    input  logic     reset,
    output busCmdT   busCmd,
    input  logic     busDone,
    input  wordT     busWord,
    output regIdxT   rsIdx,
    output regIdxT   rtIdx,
    input  wordT     rsData,
    input  wordT     rtData,
    input  wordT     v0Data,
    output regWriteT regWrite,
    output aluOpT    aluOp,
    output wordT     aluA,
    output wordT     aluB,
    output shamtT    aluShamt,
    input  wordT     aluResult,
    output logic     active,
    output wordT     registerV0
);

    cpuStateT state;
    wordT     pc;
    wordT     nextPc;
    logic     jumpPending;
    wordT     jumpTarget;
    instrT    instr;
    wordT     aluOut;

    instrT cur;
    logic  legal;
    logic  useImm;
    logic  signExt;
    logic  isLoad;
    logic  isStore;
    logic  isBranch;
    logic  isJump;
    logic  isJr;
    logic  taken;
    wordT  immExt;
    wordT  pcPlus4;
    wordT  target;

    // Fresh word from the bus while decoding, latched copy afterwards
    assign cur = (state == DECODE) ? instrT'(busWord) : instr;

    always_comb begin
        legal    = 1'b1;
        aluOp    = ALU_ADD;
        useImm   = 1'b0;
        signExt  = 1'b1;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        isBranch = 1'b0;
        isJump   = 1'b0;
        isJr     = 1'b0;
        case (cur.opcode)
            OP_SPECIAL: begin
                case (cur.low.r.funct)
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLTU: aluOp = ALU_SLTU;
                    FN_SLL:  aluOp = ALU_SLL;
                    FN_SRL:  aluOp = ALU_SRL;
                    FN_SRA:  aluOp = ALU_SRA;
                    FN_JR:   isJr  = 1'b1;
                    default: legal = 1'b0;
                endcase
            end
            OP_J:          isJump = 1'b1;
            OP_BEQ, OP_BNE: isBranch = 1'b1;
            OP_ADDIU:      useImm = 1'b1;
            OP_SLTI: begin
                aluOp  = ALU_SLT;
                useImm = 1'b1;
            end
            // Immediate is sign extended, then compared unsigned
            OP_SLTIU: begin
                aluOp  = ALU_SLTU;
                useImm = 1'b1;
            end
            OP_ANDI: begin
                aluOp   = ALU_AND;
                useImm  = 1'b1;
                signExt = 1'b0;
            end
            OP_ORI: begin
                aluOp   = ALU_OR;
                useImm  = 1'b1;
                signExt = 1'b0;
            end
            OP_XORI: begin
                aluOp   = ALU_XOR;
                useImm  = 1'b1;
                signExt = 1'b0;
            end
            OP_LUI: begin
                aluOp   = ALU_LUI;
                useImm  = 1'b1;
                signExt = 1'b0;
            end
            OP_LW: begin
                isLoad = 1'b1;
                useImm = 1'b1;
            end
            OP_SW: begin
                isStore = 1'b1;
                useImm  = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    assign immExt  = signExt ? {{16{cur.low.immediate[15]}}, cur.low.immediate}
                             : {16'h0000, cur.low.immediate};
    assign pcPlus4 = pc + 32'd4;

    // Branch offsets count from the delay slot
    always_comb begin
        if (isJr) begin
            target = rsData;
        end else if (isJump) begin
            target = {pcPlus4[31:28], cur.rs, cur.rt, cur.low.immediate, 2'b00};
        end else begin
            target = pcPlus4 + {immExt[29:0], 2'b00};
        end
    end

    assign taken = isJr || isJump
                || (isBranch && ((rsData == rtData) != (cur.opcode == OP_BNE)));

    assign rsIdx    = instr.rs;
    assign rtIdx    = instr.rt;
    assign aluA     = rsData;
    assign aluB     = useImm ? immExt : rtData;
    assign aluShamt = cur.low.r.shamt;

    always_comb begin
        busCmd.read      = (state == FETCH) || ((state == MEMORY) && isLoad);
        busCmd.write     = (state == MEMORY) && isStore;
        busCmd.address   = (state == MEMORY) ? aluOut : pc;
        busCmd.storeData = rtData;
    end

    // R-type writes rd, everything else writes rt
    always_comb begin
        regWrite.enable = (state == WRITEBACK);
        regWrite.idx    = (instr.opcode == OP_SPECIAL) ? instr.low.r.rd : instr.rt;
        regWrite.data   = isLoad ? busWord : aluOut;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= FETCH;
            pc          <= resetVector;
            jumpPending <= 1'b0;
            active      <= 1'b1;
            registerV0  <= '0;
        end else begin
            case (state)
                FETCH: begin
                    if (busDone) begin
                        jumpPending <= 1'b0;
                        state       <= DECODE;
                    end
                end
                DECODE: state <= legal ? EXECUTE : HALT;
                EXECUTE: begin
                    if (isLoad || isStore) begin
                        state <= MEMORY;
                    end else if (isBranch || isJump || isJr) begin
                        jumpPending <= taken;
                        pc          <= nextPc;
                        state       <= FETCH;
                    end else begin
                        state <= WRITEBACK;
                    end
                end
                MEMORY: begin
                    if (busDone && isLoad) begin
                        state <= WRITEBACK;
                    end else if (busDone) begin
                        pc    <= nextPc;
                        state <= FETCH;
                    end
                end
                WRITEBACK: begin
                    pc    <= nextPc;
                    state <= FETCH;
                end
                default: begin
                    active     <= 1'b0;
                    registerV0 <= v0Data;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // A pending jump redirects the instruction after the delay slot
        if (state == FETCH && busDone) begin
            nextPc <= jumpPending ? jumpTarget : pcPlus4;
        end
        if (state == DECODE) begin
            instr <= cur;
        end
        if (state == EXECUTE) begin
            aluOut     <= aluResult;
            jumpTarget <= target;
        end
    end

endmodule

// File: mipsCpuBus.sv
module mipsCpuBus import mipsPkg::*; #(
    parameter wordT resetVector = 32'hBFC0_0000
) (
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output wordT       registerV0,

    // Avalon-MM master
    output wordT       address,
    output logic       read,
    output logic       write,
    input  logic       waitrequest,
    output wordT       writedata,
    output logic [3:0] byteenable,
    input  wordT       readdata
);

    busCmdT   busCmd;
    logic     busDone;
    wordT     busWord;
    regIdxT   rsIdx;
    regIdxT   rtIdx;
    wordT     rsData;
    wordT     rtData;
    wordT     v0Data;
    regWriteT regWrite;
    aluOpT    aluOp;
    wordT     aluA;
    wordT     aluB;
    shamtT    aluShamt;
    wordT     aluResult;

    mipsSequencer #(
        .resetVector(resetVector)
    ) sequencer_i (
        .clk       (clk),
        .reset     (reset),
        .busCmd    (busCmd),
        .busDone   (busDone),
        .busWord   (busWord),
        .rsIdx     (rsIdx),
        .rtIdx     (rtIdx),
        .rsData    (rsData),
        .rtData    (rtData),
        .v0Data    (v0Data),
        .regWrite  (regWrite),
        .aluOp     (aluOp),
        .aluA      (aluA),
        .aluB      (aluB),
        .aluShamt  (aluShamt),
        .aluResult (aluResult),
        .active    (active),
        .registerV0(registerV0)
    );

    mipsRegFile regFile_i (
        .clk     (clk),
        .reset   (reset),
        .rsIdx   (rsIdx),
        .rtIdx   (rtIdx),
        .rsData  (rsData),
        .rtData  (rtData),
        .regWrite(regWrite),
        .v0Data  (v0Data)
    );

    mipsAlu alu_i (
        .aluOp    (aluOp),
        .aluA     (aluA),
        .aluB     (aluB),
        .aluShamt (aluShamt),
        .aluResult(aluResult)
    );

    mipsBusPort busPort_i (
        .clk        (clk),
        .reset      (reset),
        .busCmd     (busCmd),
        .busDone    (busDone),
        .busWord    (busWord),
        .address    (address),
        .read       (read),
        .write      (write),
        .waitrequest(waitrequest),
        .writedata  (writedata),
        .byteenable (byteenable),
        .readdata   (readdata)
    );

endmodule

// File: tbAvalonMem.sv
module tbAvalonMem import mipsPkg::*; (
    input  logic clk,
    input  logic reset,
    input  wordT address,
    input  logic read,
    input  logic write,
    output logic waitrequest,
    input  wordT writedata,
    output wordT readdata,
    output logic storeStrobe,
    output wordT storeAddr,
    output wordT storeData
);

    // Words kept in bus byte order by word address
    wordT mem [logic [29:0]];

    logic waitReg = 1'b1;
    wordT readReg = '0;

    assign waitrequest = waitReg;
    assign readdata    = readReg;

    // Unwritten locations return a pattern of the full address
    function automatic wordT readWord(input wordT a);
        if (mem.exists(a[31:2])) begin
            return mem[a[31:2]];
        end
        return a ^ 32'h5EED_0F11;
    endfunction

    // Random wait cycles from a fixed seed
    initial begin
        void'($urandom(32'hade352ca));
        forever begin
            @(posedge clk);
            if (reset) begin
                waitReg     <= 1'b1;
                storeStrobe <= 1'b0;
            end else begin
                storeStrobe <= 1'b0;
                if ((read || write) && !waitReg) begin
                    // Transfer completes on this edge
                    waitReg <= 1'b1;
                    if (write) begin
                        mem[address[31:2]] = writedata;
                        storeStrobe <= 1'b1;
                        storeAddr   <= address;
                        storeData   <= writedata;
                    end
                end else if ((read || write) && ($urandom % 4 != 0)) begin
                    waitReg <= 1'b0;
                    readReg <= readWord(address);
                end
            end
        end
    end

endmodule

// File: mipsCpuBusTb.sv
module mipsCpuBusTb import mipsPkg::*; ();

    localparam wordT resetVector = 32'hBFC0_0000;

    logic       clk;
    logic       reset = 1'b1;
    logic       active;
    wordT       registerV0;
    wordT       address;
    logic       read;
    logic       write;
    logic       waitrequest;
    wordT       writedata;
    logic [3:0] byteenable;
    wordT       readdata;
    logic       storeStrobe;
    wordT       storeAddr;
    wordT       storeData;

    // Raw stim words read as a flat list of records
    wordT stim [0:255];
    wordT expAddr [$];
    wordT expData [$];
    wordT expV0;
    int   progWords = 0;
    int   limit = 0;
    int   cycles = 0;
    int   storeCount = 0;

    mipsCpuBus #(
        .resetVector(resetVector)
    ) dut_i (
        .clk        (clk),
        .reset      (reset),
        .active     (active),
        .registerV0 (registerV0),
        .address    (address),
        .read       (read),
        .write      (write),
        .waitrequest(waitrequest),
        .writedata  (writedata),
        .byteenable (byteenable),
        .readdata   (readdata)
    );

    tbAvalonMem memModel_i (
        .clk        (clk),
        .reset      (reset),
        .address    (address),
        .read       (read),
        .write      (write),
        .waitrequest(waitrequest),
        .writedata  (writedata),
        .readdata   (readdata),
        .storeStrobe(storeStrobe),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    // Bus lanes carry the word with its bytes reversed
    function automatic wordT busToWord(input wordT w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    task automatic stopWithFailure();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            stopWithFailure();
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %b actual %b", name, expected, actual);
            stopWithFailure();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Cycle limit guards against a hung program
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("Timeout: the processor did not halt within %0d cycles", limit);
            stopWithFailure();
        end
    end

    // Stores must appear in program order with the expected values
    always @(negedge clk) begin
        if (!reset && storeStrobe) begin
            if (expAddr.size() == 0) begin
                $display("Unexpected store to %h after all expected stores", storeAddr);
                stopWithFailure();
            end else begin
                checkWord($sformatf("store %0d address", storeCount),
                          expAddr.pop_front(), storeAddr);
                checkWord($sformatf("store %0d data", storeCount),
                          expData.pop_front(), busToWord(storeData));
                storeCount = storeCount + 1;
            end
        end
    end

    // Every transfer uses all four byte lanes
    always @(negedge clk) begin
        if (!reset && (read || write)) begin
            checkBit("byteenable all lanes", 1'b1, &byteenable);
        end
    end

    initial begin
        int   i;
        int   n;
        wordT a;
        $readmemh("cpuStim.txt", stim);
        i = 0;
        while (stim[i] != 32'd0) begin
            case (stim[i])
                // Block of program or data words
                32'd1: begin
                    n = stim[i + 2];
                    for (int j = 0; j < n; j++) begin
                        a = stim[i + 1] + wordT'(j * 4);
                        memModel_i.mem[a[31:2]] = busToWord(stim[i + 3 + j]);
                    end
                    progWords = progWords + n;
                    i = i + 3 + n;
                end
                32'd2: begin
                    expAddr.push_back(stim[i + 1]);
                    expData.push_back(stim[i + 2]);
                    i = i + 3;
                end
                32'd3: begin
                    expV0 = stim[i + 1];
                    i = i + 2;
                end
                default: begin
                    $display("Unknown record kind %h in the stim file", stim[i]);
                    stopWithFailure();
                end
            endcase
        end
        // Five steps per instruction with each stretched at most eight times
        limit = progWords * 5 * 8 + 200;

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkBit("read after reset", 1'b0, read);
        checkBit("write after reset", 1'b0, write);
        checkBit("active after reset", 1'b1, active);
        checkWord("registerV0 after reset", '0, registerV0);
        while (!read) begin
            @(negedge clk);
        end
        checkWord("first fetch address", resetVector, address);

        while (active) begin
            @(negedge clk);
        end
        checkWord("registerV0 at halt", expV0, registerV0);
        if (expAddr.size() != 0) begin
            $display("Halted with %0d expected stores never seen", expAddr.size());
            stopWithFailure();
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: cpuStim.txt
// Records: 1 addr count words (memory), 2 addr data (store), 3 value (registerV0), 0 end
// Words are in normal MIPS order, the testbench swaps them onto the bus
1 BFC00000 0000003D
3C01BFC0 34210200 24021234 2403FFFB
00432021 00432823 0062302A 0062382B
00034043 00034902 00025200 01285824
01466025 00856826 286EFFFC 2C4FFFFF
3070F0F0 387100FF 00420021 AC240000
AC250004 AC260008 AC27000C AC280010
AC290014 AC2A0018 AC2B001C AC2C0020
AC2D0024 AC2E0028 AC2F002C AC300030
AC310034 AC200038 8C320100 AC32003C
24130007 12620004 24140001 AC340040
16600003 26940001 AC340044 AC200044
AC340048 12940002 26940001 AC20004C
0BF00034 AC34004C AC200050 AC200050
3C15BFC0 36B500E8 02A00008 26940001
AC200050 AC200050 AC340050 240255AA
FC000000
1 BFC00300 00000001 CAFEF00D
2 BFC00200 0000122F
2 BFC00204 00001239
2 BFC00208 00000001
2 BFC0020C 00000000
2 BFC00210 FFFFFFFD
2 BFC00214 0FFFFFFF
2 BFC00218 00123400
2 BFC0021C 0FFFFFFD
2 BFC00220 00123401
2 BFC00224 00000016
2 BFC00228 00000001
2 BFC0022C 00000001
2 BFC00230 0000F0F0
2 BFC00234 FFFFFF04
2 BFC00238 00000000
2 BFC0023C CAFEF00D
2 BFC00240 00000001
2 BFC00248 00000002
2 BFC0024C 00000003
2 BFC00250 00000004
3 000055AA
0

// File: flist.f
mipsPkg.sv
mipsAlu.sv
mipsRegFile.sv
mipsBusPort.sv
mipsSequencer.sv
mipsCpuBus.sv
tbAvalonMem.sv
mipsCpuBusTb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module mipsCpuBusTb -f flist.f -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
